// File: common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path word
`define CPU_DATA_W 32

// register file geometry
`define CPU_REG_AW 5
`define CPU_REG_NUM 32

// top three address bits of the uncached segment
`define CPU_KSEG1 3'b101
`define CPU_SEG_W 3

`endif

// File: common/mem_pkg.sv
package mem_pkg;

	// load width as issued to the data cache
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_t;

	// unaligned word merge, lwl and lwr
	typedef enum logic [1:0] {
		MERGE_NONE  = 2'd0,
		MERGE_LEFT  = 2'd1,
		MERGE_RIGHT = 2'd2
	} merge_kind_t;

endpackage

// File: common/pipe_pkg.sv
`include "cpu_params.svh"

package pipe_pkg;

	// lite lane, plain alu result
	typedef struct packed {
		logic                   valid;
		logic [`CPU_DATA_W-1:0] pc;
		logic                   wreg_en;
		logic [`CPU_REG_AW-1:0] wreg_addr;
		logic [`CPU_DATA_W-1:0] wreg_data;
	} lite_payload_t;

	// pro lane, alu result or load
	typedef struct packed {
		logic                   valid;
		logic [`CPU_DATA_W-1:0] pc;
		logic                   wreg_en;
		logic [`CPU_REG_AW-1:0] wreg_addr;
		// doubles as load address
		logic [`CPU_DATA_W-1:0] alu_ans;
		logic                   load;
		mem_pkg::access_size_t  rsize;
		logic                   sign_ext;
		mem_pkg::merge_kind_t   merge;
		// old rt for lwl/lwr
		logic [`CPU_DATA_W-1:0] rt;
		logic                   cached;
	} pro_payload_t;

endpackage

// File: logic/ex_mem_stage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module ex_mem_stage (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   flush,
	input  logic                   stall_dcache,
	input  logic                   reverse,
	input  pipe_pkg::lite_payload_t lite_in,
	input  pipe_pkg::pro_payload_t  pro_in,
	output pipe_pkg::lite_payload_t lite_out,
	output pipe_pkg::pro_payload_t  pro_out,
	output logic                   reverse_out,
	output logic                   mem_en_cached,
	output logic                   mem_en_uncached,
	output logic [`CPU_DATA_W-1:0] mem_addr,
	output mem_pkg::access_size_t  mem_rsize
);
	import pipe_pkg::*;

	lite_payload_t lite_q;
	pro_payload_t  pro_q;
	pro_payload_t  pro_next;
	logic          lite_v;
	logic          pro_v;
	logic          load_req;

	// kseg1 goes around the cache
	always_comb begin
		pro_next = pro_in;
		pro_next.cached = (pro_in.alu_ans[`CPU_DATA_W-1 -: `CPU_SEG_W] != `CPU_KSEG1);
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			lite_v <= 1'b0;
			pro_v <= 1'b0;
			reverse_out <= 1'b0;
		end else if (flush) begin
			lite_v <= 1'b0;
			pro_v <= 1'b0;
		end else if (!stall_dcache) begin
			lite_v <= lite_in.valid;
			pro_v <= pro_in.valid;
			reverse_out <= reverse;
		end
	end

	// hold on stall so the request address stays put
	always_ff @(posedge aclk) begin
		if (!stall_dcache) begin
			lite_q <= lite_in;
			pro_q <= pro_next;
		end
	end

	always_comb begin
		lite_out = lite_q;
		lite_out.valid = lite_v;
		pro_out = pro_q;
		pro_out.valid = pro_v;
	end

	assign load_req = pro_v & pro_q.load & ~flush;
	assign mem_en_cached = load_req & pro_q.cached;
	assign mem_en_uncached = load_req & ~pro_q.cached;
	assign mem_addr = pro_q.alu_ans;
	assign mem_rsize = pro_q.rsize;

endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mem_wb_stage (
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic                    stall_dcache,
	input  pipe_pkg::lite_payload_t lite_in,
	input  pipe_pkg::pro_payload_t  pro_in,
	input  logic                    reverse,
	output pipe_pkg::lite_payload_t lite_out,
	output pipe_pkg::pro_payload_t  pro_out,
	output logic                    reverse_out
);
	import pipe_pkg::*;

	lite_payload_t lite_q;
	pro_payload_t  pro_q;
	logic          lite_v;
	logic          pro_v;

	// bubble while the dcache stalls, the held ex_mem pair
	// commits once after the stall drops
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			lite_v <= 1'b0;
			pro_v <= 1'b0;
			reverse_out <= 1'b0;
		end else begin
			lite_v <= lite_in.valid & ~stall_dcache;
			pro_v <= pro_in.valid & ~stall_dcache;
			reverse_out <= reverse;
		end
	end

	always_ff @(posedge aclk) begin
		lite_q <= lite_in;
		pro_q <= pro_in;
	end

	always_comb begin
		lite_out = lite_q;
		lite_out.valid = lite_v;
		pro_out = pro_q;
		pro_out.valid = pro_v;
	end

endmodule

// File: logic/load_align.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module load_align (
	input  pipe_pkg::pro_payload_t  pro_in,
	input  logic [`CPU_DATA_W-1:0]  drdata_cached,
	input  logic [`CPU_DATA_W-1:0]  drdata_uncached,
	output logic [`CPU_DATA_W-1:0]  wreg_data
);
	import mem_pkg::*;

	localparam logic [`CPU_DATA_W-1:0] ONES = {`CPU_DATA_W{1'b1}};

	logic [1:0]             off;
	logic [4:0]             rsh;
	logic [4:0]             lsh;
	logic [`CPU_DATA_W-1:0] word;
	logic [`CPU_DATA_W-1:0] shifted;
	logic [`CPU_DATA_W-1:0] sized;
	logic [`CPU_DATA_W-1:0] loaded;

	assign off = pro_in.alu_ans[1:0];
	// little endian byte lanes
	assign rsh = {off, 3'b000};
	// 8*(3-b)
	assign lsh = {~off, 3'b000};

	assign word = pro_in.cached ? drdata_cached : drdata_uncached;
	assign shifted = word >> rsh;

	always_comb begin
		case (pro_in.rsize)
			SIZE_BYTE: sized = pro_in.sign_ext ? {{24{shifted[7]}}, shifted[7:0]}
			                                   : {24'd0, shifted[7:0]};
			SIZE_HALF: sized = pro_in.sign_ext ? {{16{shifted[15]}}, shifted[15:0]}
			                                   : {16'd0, shifted[15:0]};
			default:   sized = word;
		endcase
	end

	always_comb begin
		case (pro_in.merge)
			// lwl keeps the low bytes of rt
			MERGE_LEFT:  loaded = (word << lsh) | (pro_in.rt & ~(ONES << lsh));
			// lwr keeps the high bytes of rt
			MERGE_RIGHT: loaded = (word >> rsh) | (pro_in.rt & ~(ONES >> rsh));
			default:     loaded = sized;
		endcase
	end

	assign wreg_data = pro_in.load ? loaded : pro_in.alu_ans;

endmodule

// File: logic/commit_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module commit_unit (
	input  logic                    aclk,
	input  pipe_pkg::lite_payload_t lite_in,
	input  logic                    pro_valid,
	input  logic                    pro_wreg_en,
	input  logic [`CPU_REG_AW-1:0]  pro_wreg_addr,
	input  logic [`CPU_DATA_W-1:0]  pro_pc,
	input  logic [`CPU_DATA_W-1:0]  pro_wdata,
	input  logic                    reverse,
	input  logic [`CPU_REG_AW-1:0]  rd_addr1,
	input  logic [`CPU_REG_AW-1:0]  rd_addr2,
	output logic [`CPU_DATA_W-1:0]  rd_data1,
	output logic [`CPU_DATA_W-1:0]  rd_data2,
	output logic [`CPU_DATA_W-1:0]  debug_first_pc,
	output logic [3:0]              debug_first_wen,
	output logic [`CPU_REG_AW-1:0]  debug_first_wnum,
	output logic [`CPU_DATA_W-1:0]  debug_first_wdata,
	output logic [`CPU_DATA_W-1:0]  debug_second_pc,
	output logic [3:0]              debug_second_wen,
	output logic [`CPU_REG_AW-1:0]  debug_second_wnum,
	output logic [`CPU_DATA_W-1:0]  debug_second_wdata
);
	logic [`CPU_DATA_W-1:0] rf [0:`CPU_REG_NUM-1];
	logic                   lite_we;
	logic                   pro_we;

	assign lite_we = lite_in.valid & lite_in.wreg_en;
	assign pro_we = pro_valid & pro_wreg_en;

	// first is older in program order
	always_comb begin
		if (reverse) begin
			debug_first_pc = lite_in.pc;
			debug_first_wen = {4{lite_we}};
			debug_first_wnum = lite_in.wreg_addr;
			debug_first_wdata = lite_in.wreg_data;
			debug_second_pc = pro_pc;
			debug_second_wen = {4{pro_we}};
			debug_second_wnum = pro_wreg_addr;
			debug_second_wdata = pro_wdata;
		end else begin
			debug_first_pc = pro_pc;
			debug_first_wen = {4{pro_we}};
			debug_first_wnum = pro_wreg_addr;
			debug_first_wdata = pro_wdata;
			debug_second_pc = lite_in.pc;
			debug_second_wen = {4{lite_we}};
			debug_second_wnum = lite_in.wreg_addr;
			debug_second_wdata = lite_in.wreg_data;
		end
	end

	// younger write comes last and wins on a clash
	always_ff @(posedge aclk) begin
		if (debug_first_wen[0] && debug_first_wnum != '0) begin
			rf[debug_first_wnum] <= debug_first_wdata;
		end
		if (debug_second_wen[0] && debug_second_wnum != '0) begin
			rf[debug_second_wnum] <= debug_second_wdata;
		end
	end

	assign rd_data1 = (rd_addr1 == '0) ? '0 : rf[rd_addr1];
	assign rd_data2 = (rd_addr2 == '0) ? '0 : rf[rd_addr2];

endmodule

// File: logic/commit_pipe.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module commit_pipe (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   flush,
	input  logic                   stall_dcache,
	input  logic                   reverse,
	input  logic                   lite_valid,
	input  logic [`CPU_DATA_W-1:0] lite_pc,
	input  logic                   lite_wreg_en,
	input  logic [`CPU_REG_AW-1:0] lite_wreg_addr,
	input  logic [`CPU_DATA_W-1:0] lite_wreg_data,
	input  logic                   pro_valid,
	input  logic [`CPU_DATA_W-1:0] pro_pc,
	input  logic                   pro_wreg_en,
	input  logic [`CPU_REG_AW-1:0] pro_wreg_addr,
	input  logic [`CPU_DATA_W-1:0] pro_alu_ans,
	input  logic                   pro_load,
	input  mem_pkg::access_size_t  pro_rsize,
	input  logic                   pro_sign_ext,
	input  mem_pkg::merge_kind_t   pro_merge,
	input  logic [`CPU_DATA_W-1:0] pro_rt,
	input  logic [`CPU_DATA_W-1:0] drdata_cached,
	input  logic [`CPU_DATA_W-1:0] drdata_uncached,
	output logic                   mem_en_cached,
	output logic                   mem_en_uncached,
	output logic [`CPU_DATA_W-1:0] mem_addr,
	output mem_pkg::access_size_t  mem_rsize,
	input  logic [`CPU_REG_AW-1:0] rd_addr1,
	input  logic [`CPU_REG_AW-1:0] rd_addr2,
	output logic [`CPU_DATA_W-1:0] rd_data1,
	output logic [`CPU_DATA_W-1:0] rd_data2,
	output logic [`CPU_DATA_W-1:0] debug_first_pc,
	output logic [3:0]             debug_first_wen,
	output logic [`CPU_REG_AW-1:0] debug_first_wnum,
	output logic [`CPU_DATA_W-1:0] debug_first_wdata,
	output logic [`CPU_DATA_W-1:0] debug_second_pc,
	output logic [3:0]             debug_second_wen,
	output logic [`CPU_REG_AW-1:0] debug_second_wnum,
	output logic [`CPU_DATA_W-1:0] debug_second_wdata
);
	import pipe_pkg::*;

	lite_payload_t          lite_in;
	pro_payload_t           pro_in;
	lite_payload_t          ex_mem_lite;
	pro_payload_t           ex_mem_pro;
	logic                   ex_mem_reverse;
	lite_payload_t          mem_wb_lite;
	pro_payload_t           mem_wb_pro;
	logic                   mem_wb_reverse;
	logic [`CPU_DATA_W-1:0] mem_wb_pro_wdata;

	assign lite_in = '{valid: lite_valid, pc: lite_pc, wreg_en: lite_wreg_en,
		wreg_addr: lite_wreg_addr, wreg_data: lite_wreg_data};

	// cached bit is filled in by ex_mem
	assign pro_in = '{valid: pro_valid, pc: pro_pc, wreg_en: pro_wreg_en,
		wreg_addr: pro_wreg_addr, alu_ans: pro_alu_ans, load: pro_load,
		rsize: pro_rsize, sign_ext: pro_sign_ext, merge: pro_merge,
		rt: pro_rt, cached: 1'b0};

	ex_mem_stage u_ex_mem (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.flush           (flush),
		.stall_dcache    (stall_dcache),
		.reverse         (reverse),
		.lite_in         (lite_in),
		.pro_in          (pro_in),
		.lite_out        (ex_mem_lite),
		.pro_out         (ex_mem_pro),
		.reverse_out     (ex_mem_reverse),
		.mem_en_cached   (mem_en_cached),
		.mem_en_uncached (mem_en_uncached),
		.mem_addr        (mem_addr),
		.mem_rsize       (mem_rsize)
	);

	mem_wb_stage u_mem_wb (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.stall_dcache (stall_dcache),
		.lite_in      (ex_mem_lite),
		.pro_in       (ex_mem_pro),
		.reverse      (ex_mem_reverse),
		.lite_out     (mem_wb_lite),
		.pro_out      (mem_wb_pro),
		.reverse_out  (mem_wb_reverse)
	);

	load_align u_load_align (
		.pro_in          (mem_wb_pro),
		.drdata_cached   (drdata_cached),
		.drdata_uncached (drdata_uncached),
		.wreg_data       (mem_wb_pro_wdata)
	);

	commit_unit u_commit (
		.aclk               (aclk),
		.lite_in            (mem_wb_lite),
		.pro_valid          (mem_wb_pro.valid),
		.pro_wreg_en        (mem_wb_pro.wreg_en),
		.pro_wreg_addr      (mem_wb_pro.wreg_addr),
		.pro_pc             (mem_wb_pro.pc),
		.pro_wdata          (mem_wb_pro_wdata),
		.reverse            (mem_wb_reverse),
		.rd_addr1           (rd_addr1),
		.rd_addr2           (rd_addr2),
		.rd_data1           (rd_data1),
		.rd_data2           (rd_data2),
		.debug_first_pc     (debug_first_pc),
		.debug_first_wen    (debug_first_wen),
		.debug_first_wnum   (debug_first_wnum),
		.debug_first_wdata  (debug_first_wdata),
		.debug_second_pc    (debug_second_pc),
		.debug_second_wen   (debug_second_wen),
		.debug_second_wnum  (debug_second_wnum),
		.debug_second_wdata (debug_second_wdata)
	);

endmodule

// File: testbench/commit_pipe_assert.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module commit_pipe_assert (
	input logic                   aclk,
	input logic                   aresetn,
	input logic                   flush,
	input logic                   stall_dcache,
	input logic                   mem_en_cached,
	input logic                   mem_en_uncached,
	input logic [`CPU_DATA_W-1:0] mem_addr,
	input logic [3:0]             debug_first_wen,
	input logic [3:0]             debug_second_wen
);

	// one port per load, picked by the kseg1 segment
	a_port_excl: assert property (@(posedge aclk) disable iff (!aresetn)
		(mem_en_cached || mem_en_uncached) |->
		(!(mem_en_cached && mem_en_uncached)
		&& (mem_en_uncached == (mem_addr[`CPU_DATA_W-1 -: `CPU_SEG_W] == `CPU_KSEG1))))
		else $error("memory port does not match the address segment");

	// flushed request stays quiet in the next cycle too
	a_flush_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
		flush |-> !(mem_en_cached || mem_en_uncached)
		##1 !(mem_en_cached || mem_en_uncached))
		else $error("memory enable high during or after flush");

	a_addr_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		stall_dcache |=> $stable(mem_addr))
		else $error("mem_addr moved across a stall");

	// stalled access must not commit in the bubble cycle
	a_stall_bubble: assert property (@(posedge aclk) disable iff (!aresetn)
		stall_dcache |=> (debug_first_wen == 4'd0 && debug_second_wen == 4'd0))
		else $error("commit in the cycle after a stall");

endmodule

bind commit_pipe commit_pipe_assert u_assert (.*);

// File: testbench/tb_commit_pipe.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_commit_pipe;
	import mem_pkg::*;

	localparam int WINDOW = 10;

	typedef struct {
		logic rev;
		logic flush;
		int stall;
		logic l_valid;
		logic l_we;
		logic [4:0] l_wa;
		logic [31:0] l_wd;
		logic p_valid;
		logic p_we;
		logic [4:0] p_wa;
		logic [31:0] p_alu;
		logic p_load;
		access_size_t p_size;
		logic p_sext;
		merge_kind_t p_merge;
		logic [31:0] word;
	} row_t;

	logic aclk, aresetn, flush, stall_dcache, reverse;
	logic lite_valid, lite_wreg_en, pro_valid, pro_wreg_en, pro_load, pro_sign_ext;
	logic [31:0] lite_pc, lite_wreg_data, pro_pc, pro_alu_ans, pro_rt;
	logic [4:0] lite_wreg_addr, pro_wreg_addr, rd_addr1, rd_addr2;
	access_size_t pro_rsize, mem_rsize;
	merge_kind_t pro_merge;
	logic [31:0] drdata_cached, drdata_uncached, mem_addr, rd_data1, rd_data2;
	logic mem_en_cached, mem_en_uncached;
	logic [31:0] debug_first_pc, debug_first_wdata, debug_second_pc, debug_second_wdata;
	logic [3:0] debug_first_wen, debug_second_wen;
	logic [4:0] debug_first_wnum, debug_second_wnum;

	row_t rows[$];
	bit [31:0] mem_words[bit [29:0]];
	logic [31:0] filler_base, mem_data, ref_rf[32];
	logic seen_cached, seen_uncached;
	bit written[32];
	int errors, row_errors, tests, b;

	commit_pipe u_dut (.*);

	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	// memory model answers in write-back from the address of the cycle before
	always @(posedge aclk) begin
		mem_data <= mem_words.exists(mem_addr[31:2]) ? mem_words[mem_addr[31:2]]
		                                             : filler_base ^ {mem_addr[31:2], 2'b00};
		seen_cached <= mem_en_cached;
		seen_uncached <= mem_en_uncached;
	end
	// wrong port gives inverted data
	assign drdata_cached = seen_cached ? mem_data : ~mem_data;
	assign drdata_uncached = seen_uncached ? mem_data : ~mem_data;

	function automatic logic [31:0] ref_load(input logic [31:0] w, input logic [31:0] a,
			input access_size_t sz, input logic sx, input merge_kind_t mk, input logic [31:0] rt);
		logic [7:0] wb[4];
		logic [7:0] rb[4];
		logic [31:0] res;
		int o;
		o = int'(a[1:0]);
		for (int i = 0; i < 4; i++) begin
			wb[i] = w[8*i +: 8];
			rb[i] = rt[8*i +: 8];
		end
		res = w;
		if (mk == MERGE_LEFT) begin
			for (int i = 0; i < 4; i++)
				res[8*i +: 8] = (i >= 3 - o) ? wb[(i - (3 - o)) & 3] : rb[i];
		end else if (mk == MERGE_RIGHT) begin
			for (int i = 0; i < 4; i++)
				res[8*i +: 8] = (i + o <= 3) ? wb[(i + o) & 3] : rb[i];
		end else if (sz == SIZE_BYTE) begin
			res = {{24{sx & wb[o][7]}}, wb[o]};
		end else if (sz == SIZE_HALF) begin
			res = {{16{sx & wb[(o + 1) & 3][7]}}, wb[(o + 1) & 3], wb[o]};
		end
		return res;
	endfunction

	function automatic row_t blank_row();
		row_t r;
		r.rev = 0;
		r.flush = 0;
		r.stall = 0;
		r.l_valid = 1;
		r.l_we = 0;
		r.l_wa = 0;
		r.l_wd = 0;
		r.p_valid = 1;
		r.p_we = 1;
		r.p_wa = 0;
		r.p_alu = 0;
		r.p_load = 0;
		r.p_size = SIZE_WORD;
		r.p_sext = 0;
		r.p_merge = MERGE_NONE;
		r.word = 0;
		return r;
	endfunction

	task automatic add_alu(input logic rev, input logic [4:0] la, input logic [31:0] ld,
			input logic [4:0] pa, input logic [31:0] pd, input logic fl);
		row_t r;
		r = blank_row();
		r.rev = rev;
		r.flush = fl;
		r.l_we = 1;
		r.l_wa = la;
		r.l_wd = ld;
		r.p_wa = pa;
		r.p_alu = pd;
		rows.push_back(r);
	endtask

	task automatic add_load(input logic [4:0] pa, input logic [31:0] addr, input access_size_t sz,
			input logic sx, input merge_kind_t mk, input logic [31:0] w, input int st,
			input logic fl);
		row_t r;
		r = blank_row();
		r.p_wa = pa;
		r.p_alu = addr;
		r.p_load = 1;
		r.p_size = sz;
		r.p_sext = sx;
		r.p_merge = mk;
		r.word = w;
		r.stall = st;
		r.flush = fl;
		rows.push_back(r);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
			row_errors++;
		end
	endtask

	task automatic idle_inputs();
		lite_valid = 0;
		lite_pc = 0;
		lite_wreg_en = 0;
		lite_wreg_addr = 0;
		lite_wreg_data = 0;
		pro_valid = 0;
		pro_pc = 0;
		pro_wreg_en = 0;
		pro_wreg_addr = 0;
		pro_alu_ans = 0;
		pro_load = 0;
		pro_rsize = SIZE_WORD;
		pro_sign_ext = 0;
		pro_merge = MERGE_NONE;
		pro_rt = 0;
		reverse = 0;
		flush = 0;
	endtask

	task automatic run_row(input int idx);
		row_t r;
		logic [31:0] rt, exp_pro, e_pc[2], e_wd[2];
		logic [4:0] e_wa[2];
		logic e_we[2], unc, seen, lw, pw;
		r = rows[idx];
		row_errors = 0;
		seen = 0;
		rt = $urandom;
		unc = (r.p_alu[31:29] == `CPU_KSEG1);
		exp_pro = r.p_load ? ref_load(r.word, r.p_alu, r.p_size, r.p_sext, r.p_merge, rt)
		                   : r.p_alu;
		if (r.p_load)
			mem_words[r.p_alu[31:2]] = r.word;
		lw = r.l_valid & r.l_we;
		pw = r.p_valid & r.p_we;
		e_pc[0] = r.rev ? 32'h0040_0004 + idx * 8 : 32'h0040_0000 + idx * 8;
		e_pc[1] = r.rev ? 32'h0040_0000 + idx * 8 : 32'h0040_0004 + idx * 8;
		e_we[0] = r.rev ? lw : pw;
		e_we[1] = r.rev ? pw : lw;
		e_wa[0] = r.rev ? r.l_wa : r.p_wa;
		e_wa[1] = r.rev ? r.p_wa : r.l_wa;
		e_wd[0] = r.rev ? r.l_wd : exp_pro;
		e_wd[1] = r.rev ? exp_pro : r.l_wd;
		@(posedge aclk);
		#1;
		reverse = r.rev;
		flush = r.flush;
		lite_valid = r.l_valid;
		lite_pc = 32'h0040_0004 + idx * 8;
		lite_wreg_en = r.l_we;
		lite_wreg_addr = r.l_wa;
		lite_wreg_data = r.l_wd;
		pro_valid = r.p_valid;
		pro_pc = 32'h0040_0000 + idx * 8;
		pro_wreg_en = r.p_we;
		pro_wreg_addr = r.p_wa;
		pro_alu_ans = r.p_alu;
		pro_load = r.p_load;
		pro_rsize = r.p_size;
		pro_sign_ext = r.p_sext;
		pro_merge = r.p_merge;
		pro_rt = rt;
		@(posedge aclk);
		#1;
		idle_inputs();
		stall_dcache = (r.stall > 0);
		for (int k = 0; k < WINDOW; k++) begin
			@(negedge aclk);
			if (k <= r.stall && r.p_load && !r.flush) begin
				check_val("mem_en_cached", 32'(mem_en_cached), 32'(!unc));
				check_val("mem_en_uncached", 32'(mem_en_uncached), 32'(unc));
				check_val("mem_addr", mem_addr, r.p_alu);
				check_val("mem_rsize", 32'(mem_rsize), 32'(r.p_size));
			end else begin
				check_val("mem_en_cached", 32'(mem_en_cached), 0);
				check_val("mem_en_uncached", 32'(mem_en_uncached), 0);
			end
			if (debug_first_wen != 0 || debug_second_wen != 0) begin
				if (r.flush || seen || k != r.stall + 1) begin
					$display("row %0d: commit at the wrong time or more than once", idx);
					errors++;
					row_errors++;
				end else begin
					seen = 1;
					check_val("debug_first_pc", debug_first_pc, e_pc[0]);
					check_val("debug_second_pc", debug_second_pc, e_pc[1]);
					check_val("debug_first_wen", 32'(debug_first_wen), e_we[0] ? 32'hf : 0);
					check_val("debug_second_wen", 32'(debug_second_wen), e_we[1] ? 32'hf : 0);
					for (int s = 0; s < 2; s++) begin
						if (e_we[s] && e_wa[s] != 0) begin
							ref_rf[e_wa[s]] = e_wd[s];
							written[e_wa[s]] = 1;
						end
					end
					if (e_we[0]) begin
						check_val("debug_first_wnum", 32'(debug_first_wnum), 32'(e_wa[0]));
						check_val("debug_first_wdata", debug_first_wdata, e_wd[0]);
					end
					if (e_we[1]) begin
						check_val("debug_second_wnum", 32'(debug_second_wnum), 32'(e_wa[1]));
						check_val("debug_second_wdata", debug_second_wdata, e_wd[1]);
					end
				end
			end
			@(posedge aclk);
			#1;
			stall_dcache = (k + 1 < r.stall);
		end
		if (!r.flush && !seen) begin
			$display("row %0d: timed out waiting for the commit", idx);
			errors++;
			row_errors++;
		end
		rd_addr1 = r.l_wa;
		rd_addr2 = r.p_wa;
		#1;
		if (r.l_wa == 0 || written[r.l_wa])
			check_val("rd_data1", rd_data1, r.l_wa == 0 ? 32'd0 : ref_rf[r.l_wa]);
		if (r.p_wa == 0 || written[r.p_wa])
			check_val("rd_data2", rd_data2, r.p_wa == 0 ? 32'd0 : ref_rf[r.p_wa]);
		tests++;
		$display("row %0d %s", idx, row_errors == 0 ? "ok" : "failed");
	endtask

	initial begin
		void'($urandom(32'h538c_f9df));
		filler_base = $urandom;
		errors = 0;
		tests = 0;
		aresetn = 0;
		stall_dcache = 0;
		rd_addr1 = 0;
		rd_addr2 = 0;
		idle_inputs();
		// valid load traffic while reset is held
		lite_valid = 1;
		lite_wreg_en = 1;
		pro_valid = 1;
		pro_wreg_en = 1;
		pro_load = 1;
		repeat (10) @(posedge aclk);
		#1;
		aresetn = 1;
		idle_inputs();
		@(negedge aclk);
		row_errors = 0;
		check_val("debug_first_wen", 32'(debug_first_wen), 0);
		check_val("debug_second_wen", 32'(debug_second_wen), 0);
		check_val("mem_en_cached", 32'(mem_en_cached), 0);
		check_val("mem_en_uncached", 32'(mem_en_uncached), 0);
		tests++;
		$display("reset %s", row_errors == 0 ? "ok" : "failed");

		add_alu(0, 5'd1, 32'h1111_0001, 5'd2, 32'h2222_0002, 0);
		add_alu(1, 5'd3, 32'h3333_0003, 5'd4, 32'h4444_0004, 0);
		// same register so the younger lane wins
		add_alu(0, 5'd5, 32'h5555_aaaa, 5'd5, 32'h5555_bbbb, 0);
		add_alu(1, 5'd6, 32'h6666_aaaa, 5'd6, 32'h6666_bbbb, 0);
		add_alu(0, 5'd0, 32'hdead_0000, 5'd7, 32'h7777_0007, 0);
		add_load(5'd8, 32'h0000_1001, SIZE_BYTE, 1, MERGE_NONE, 32'h8a7f_c355, 0, 0);
		add_load(5'd9, 32'h0000_1003, SIZE_BYTE, 0, MERGE_NONE, 32'h8a7f_c355, 0, 0);
		add_load(5'd10, 32'h0000_2002, SIZE_HALF, 1, MERGE_NONE, 32'h9abc_1234, 0, 0);
		add_load(5'd11, 32'ha000_0100, SIZE_HALF, 0, MERGE_NONE, 32'h0102_f0e0, 0, 0);
		add_load(5'd12, 32'hbfc0_0008, SIZE_WORD, 0, MERGE_NONE, 32'hcafe_f00d, 0, 0);
		for (b = 0; b < 4; b++)
			add_load(5'd13, 32'h3000_0040 + b, SIZE_WORD, 0, MERGE_LEFT, 32'h4433_2211, 0, 0);
		for (b = 0; b < 4; b++)
			add_load(5'd14, 32'ha300_0080 + b, SIZE_WORD, 0, MERGE_RIGHT, 32'h8877_6655, 0, 0);
		// flushed pair never reaches registers 1 and 2
		add_alu(0, 5'd1, 32'hbad0_0001, 5'd2, 32'hbad0_0002, 1);
		// flushed load raises no enable and leaves register 2 alone
		add_load(5'd2, 32'ha000_0200, SIZE_WORD, 0, MERGE_NONE, 32'hbad0_0003, 0, 1);
		add_load(5'd15, 32'h0000_3000, SIZE_WORD, 0, MERGE_NONE, 32'h1357_9bdf, 3, 0);

		for (int i = 0; i < rows.size(); i++)
			run_row(i);

		$display("tests %0d errors %0d", tests, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: project.f
+incdir+common
common/mem_pkg.sv
common/pipe_pkg.sv
logic/ex_mem_stage.sv
logic/mem_wb_stage.sv
logic/load_align.sv
logic/commit_unit.sv
logic/commit_pipe.sv
testbench/commit_pipe_assert.sv
testbench/tb_commit_pipe.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_commit_pipe -f project.f -o sim_commit_pipe

./obj_dir/sim_commit_pipe | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	exit 0
else
	exit 1
fi
